/* Bender.yml */
package:
  name: cp0

sources:
  - include_dirs:
      - common
    files:
      - common/cp0RegPkg.sv
      - common/cp0ExcPkg.sv
      - common/cp0ExcIf.sv
      - exception/cp0ExcDecode.sv
      - exception/cp0ExcUnit.sv
      - timer/cp0Interrupts.sv
      - design/cp0ReadMux.sv
      - design/cp0Top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/cp0ClkGen.sv
      - dv/cp0Tb.sv

/* common/cp0ExcIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded exception report, decoder to exception unit.
// No handshake, the unit takes it at the next edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

interface cp0ExcIf;
    import cp0ExcPkg::*;

    logic                    trap;          // Entry, not ERET or refetch
    logic                    eret;
    logic                    codeValid;
    excCode_e                code;
    logic                    badAddrValid;
    logic [`CP0_DATA_W-1:0]  badAddr;
    logic [`CP0_DATA_W-1:0]  epcCandidate;
    logic                    inDelaySlot;

    modport decoder (output trap, eret, codeValid, code, badAddrValid, badAddr,
                     epcCandidate, inDelaySlot);
    modport unit (input trap, eret, codeValid, code, badAddrValid, badAddr,
                  epcCandidate, inDelaySlot);
endinterface

/* common/cp0ExcPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exception types reported by the pipeline
// and the architectural Cause.ExcCode values.
// Used by the decoder, the exception unit and the read mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cp0ExcPkg;

    // Report from the memory stage, one per cycle
    typedef enum logic [4:0] {
        ExcNone,
        ExcInterrupt,
        ExcIfAddrErr,      // Misaligned fetch
        ExcLoadAddrErr,
        ExcStoreAddrErr,
        ExcReservedInstr,
        ExcSyscall,
        ExcBreak,
        ExcTrap,
        ExcOverflow,
        ExcEret,
        ExcRefetch         // Pipeline flush, no state change
    } excType_e;

    typedef enum logic [4:0] {
        CodeInt  = 5'd0,
        CodeAdEL = 5'd4,
        CodeAdES = 5'd5,
        CodeSys  = 5'd8,
        CodeBp   = 5'd9,
        CodeRi   = 5'd10,
        CodeOv   = 5'd12,
        CodeTr   = 5'd13
    } excCode_e;

endpackage

/* common/cp0RegPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CP0 register numbers and the register-side types.
// Software write requests and the Status fields are
// passed between blocks with these types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

package cp0RegPkg;

    // Register numbers seen by MTC0/MFC0
    typedef enum logic [`CP0_ADDR_W-1:0] {
        RegBadVAddr = 5'd8,
        RegCount    = 5'd9,
        RegCompare  = 5'd11,
        RegStatus   = 5'd12,
        RegCause    = 5'd13,
        RegEpc      = 5'd14,
        RegPrid     = 5'd15
    } cp0Addr_e;

    typedef struct packed {
        logic                    en;
        cp0Addr_e                addr;
        logic [`CP0_DATA_W-1:0]  data;
    } cp0WrReq_t;

    // Implemented Status bits only
    typedef struct packed {
        logic        bev;
        logic [7:0]  im;
        logic        exl;
        logic        ie;
    } cp0Status_t;

endpackage

/* common/cp0_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes and constants of the CP0 block.
// Include wherever a width or a reset constant is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// Datapath and register number widths
`define CP0_DATA_W 32
`define CP0_ADDR_W 5

// External interrupt lines, mapped onto Cause.IP7..2
`define CP0_HW_IRQ_N 6

// Processor id, read only
`define CP0_PRID_VALUE 32'h00004220

// All ones so Count cannot hit Compare right after reset
`define CP0_COMPARE_RST 32'hFFFF_FFFF

`define CP0_DS_OFFSET 32'd4    // Branch sits one word before a delay slot

`endif

/* design/cp0ReadMux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MFC0 read path. Packs the held fields into the
// architectural layout of the addressed register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

module cp0ReadMux (
    input  logic [`CP0_ADDR_W-1:0]   rdAddr,
    input  cp0RegPkg::cp0Status_t    status,
    input  logic [`CP0_DATA_W-1:0]   epc,
    input  logic [`CP0_DATA_W-1:0]   badVAddr,
    input  logic                     causeBd,
    input  cp0ExcPkg::excCode_e      excCode,
    input  logic [`CP0_DATA_W-1:0]   count,
    input  logic [`CP0_DATA_W-1:0]   compare,
    input  logic                     causeTi,
    input  logic [7:0]               causeIp,
    output logic [`CP0_DATA_W-1:0]   rdData
);
    import cp0RegPkg::*;

    always_comb begin
        rdData = '0;    // Unimplemented numbers read zero
        case (cp0Addr_e'(rdAddr))
            RegBadVAddr: rdData = badVAddr;
            RegCount:    rdData = count;
            RegCompare:  rdData = compare;
            RegStatus:   rdData = {9'b0, status.bev, 6'b0, status.im, 6'b0, status.exl, status.ie};
            RegCause:    rdData = {causeBd, causeTi, 14'b0, causeIp, 1'b0, excCode, 2'b0};
            RegEpc:      rdData = epc;
            RegPrid:     rdData = `CP0_PRID_VALUE;
            default:     rdData = '0;
        endcase
    end

endmodule

/* design/cp0Top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CP0 system control block, top level.
// Plain pipeline side port: one write, one read and one
// exception report per cycle, no flow control.
// Writes and exceptions land at the sampling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

module cp0Top (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`CP0_HW_IRQ_N-1:0]   hwIrq,
    input  logic                       wrEn,
    input  logic [`CP0_ADDR_W-1:0]     wrAddr,
    input  logic [`CP0_DATA_W-1:0]     wrData,
    input  logic [`CP0_ADDR_W-1:0]     rdAddr,
    output logic [`CP0_DATA_W-1:0]     rdData,
    input  cp0ExcPkg::excType_e        excType,
    input  logic [`CP0_DATA_W-1:0]     excPc,
    input  logic                       excInDelaySlot,
    input  logic [`CP0_DATA_W-1:0]     excBadAddr,
    output logic                       statusBev,
    output logic [7:0]                 statusIm,
    output logic                       statusExl,
    output logic                       statusIe,
    output logic [7:0]                 causeIp,
    output logic [`CP0_DATA_W-1:0]     epc
);
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    cp0WrReq_t               wrReq;
    cp0Status_t              status;
    logic [`CP0_DATA_W-1:0]  badVAddr;
    logic                    causeBd;
    excCode_e                excCode;
    logic [`CP0_DATA_W-1:0]  count;
    logic [`CP0_DATA_W-1:0]  compare;
    logic                    causeTi;

    cp0ExcIf excBus ();

    assign wrReq = '{en: wrEn, addr: cp0Addr_e'(wrAddr), data: wrData};

    assign statusBev = status.bev;
    assign statusIm  = status.im;
    assign statusExl = status.exl;
    assign statusIe  = status.ie;

    cp0ExcDecode decode (
        .excType        (excType),
        .excPc          (excPc),
        .excInDelaySlot (excInDelaySlot),
        .excBadAddr     (excBadAddr),
        .excBus         (excBus.decoder)
    );

    cp0ExcUnit execute (
        .clk      (clk),
        .rstN     (rstN),
        .wrReq    (wrReq),
        .excBus   (excBus.unit),
        .status   (status),
        .epc      (epc),
        .badVAddr (badVAddr),
        .causeBd  (causeBd),
        .excCode  (excCode)
    );

    cp0Interrupts timer (
        .clk     (clk),
        .rstN    (rstN),
        .wrReq   (wrReq),
        .hwIrq   (hwIrq),
        .count   (count),
        .compare (compare),
        .causeTi (causeTi),
        .causeIp (causeIp)
    );

    cp0ReadMux result (
        .rdAddr   (rdAddr),
        .status   (status),
        .epc      (epc),
        .badVAddr (badVAddr),
        .causeBd  (causeBd),
        .excCode  (excCode),
        .count    (count),
        .compare  (compare),
        .causeTi  (causeTi),
        .causeIp  (causeIp),
        .rdData   (rdData)
    );

endmodule

/* dv/cp0ClkGen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock and reset source for the CP0 testbench.
// Period of 4 time units, reset held for ResetCycles edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cp0ClkGen #(
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rstN
);
    localparam int HalfPeriod = 2;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* dv/cp0Tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CP0 block.
// Replays dv/cp0_stim.txt one line per cycle. Inputs go in on the
// falling edge and the listed check is made at the next falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

module cp0Tb;
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    localparam int ResetTimeout = 100;    // Cycles

    logic                      clk;
    logic                      rstN;
    logic [`CP0_HW_IRQ_N-1:0]  hwIrq;
    logic                      wrEn;
    logic [`CP0_ADDR_W-1:0]    wrAddr;
    logic [`CP0_DATA_W-1:0]    wrData;
    logic [`CP0_ADDR_W-1:0]    rdAddr;
    logic [`CP0_DATA_W-1:0]    rdData;
    excType_e                  excType;
    logic [`CP0_DATA_W-1:0]    excPc;
    logic                      excInDelaySlot;
    logic [`CP0_DATA_W-1:0]    excBadAddr;
    logic                      statusBev;
    logic [7:0]                statusIm;
    logic                      statusExl;
    logic                      statusIe;
    logic [7:0]                causeIp;
    logic [`CP0_DATA_W-1:0]    epc;

    int errorCount = 0;
    int checkCount = 0;
    int stepNum    = 0;

    cp0ClkGen #(.ResetCycles(10)) clkGen (.clk(clk), .rstN(rstN));

    cp0Top dut0 (.*);

    // Status ports against the fields of an expected Status read
    task automatic checkStatusPorts(input logic [31:0] expected);
        logic [10:0] observed;
        logic [10:0] wanted;
        observed = {statusBev, statusIm, statusExl, statusIe};
        wanted   = {expected[22], expected[15:8], expected[1], expected[0]};
        checkCount++;
        if (observed !== wanted) begin
            errorCount++;
            $display("ERR statusBev,statusIm,statusExl,statusIe got %h expected %h at step %0d",
                     observed, wanted, stepNum);
        end
    endtask

    // Mode 1 rdData, 2 {statusExl, causeIp}, 3 epc, 0 nothing
    task automatic checkOutputs(input logic [31:0] mode, input logic [31:0] expected);
        logic [31:0] observed;
        string       name;
        observed = '0;
        name     = "";
        case (mode)
            0: return;
            1: begin
                name     = "rdData";
                observed = rdData;
                if (rdAddr == RegStatus)
                    checkStatusPorts(expected);
            end
            2: begin
                name     = "statusExl,causeIp";
                observed = {23'b0, statusExl, causeIp};
            end
            3: begin
                name     = "epc";
                observed = epc;
            end
            default: begin
                errorCount++;
                $display("Step %0d has an unknown check code %0d", stepNum, mode);
                return;
            end
        endcase
        checkCount++;
        if (observed !== expected) begin
            errorCount++;
            $display("ERR %s got %h expected %h at step %0d", name, observed, expected, stepNum);
        end
    endtask

    task automatic waitForReset(output bit released);
        int waited;
        waited = 0;
        while (!rstN && waited < ResetTimeout) begin
            @(negedge clk);
            waited++;
        end
        released = rstN;
    endtask

    task automatic replayStimulus();
        int          fd;
        int          nFields;
        string       line;
        logic [31:0] fWrEn, fWrAddr, fWrData, fExcType, fExcPc, fDelaySlot;
        logic [31:0] fBadAddr, fHwIrq, fRdAddr, fMode, fExpected;
        fd = $fopen("dv/cp0_stim.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the stimulus file dv/cp0_stim.txt");
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.substr(0, 1) == "//")
                continue;
            nFields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                              fWrEn, fWrAddr, fWrData, fExcType, fExcPc, fDelaySlot,
                              fBadAddr, fHwIrq, fRdAddr, fMode, fExpected);
            if (nFields != 11)
                continue;    // Blank line
            wrEn           = fWrEn[0];
            wrAddr         = fWrAddr[`CP0_ADDR_W-1:0];
            wrData         = fWrData;
            excType        = excType_e'(fExcType[4:0]);
            excPc          = fExcPc;
            excInDelaySlot = fDelaySlot[0];
            excBadAddr     = fBadAddr;
            hwIrq          = fHwIrq[`CP0_HW_IRQ_N-1:0];
            rdAddr         = fRdAddr[`CP0_ADDR_W-1:0];
            @(negedge clk);
            checkOutputs(fMode, fExpected);
            stepNum++;
        end
        $fclose(fd);
        if (stepNum == 0) begin
            errorCount++;
            $display("The stimulus file holds no usable lines");
        end
    endtask

    initial begin
        bit released;
        wrEn           = 1'b0;
        wrAddr         = '0;
        wrData         = '0;
        rdAddr         = '0;
        excType        = ExcNone;
        excPc          = '0;
        excInDelaySlot = 1'b0;
        excBadAddr     = '0;
        hwIrq          = '0;

        waitForReset(released);
        if (!released) begin
            errorCount++;
            $display("Reset was not released within %0d cycles", ResetTimeout);
        end else begin
            replayStimulus();
        end
        $display("Steps: %0d, checks: %0d, errors: %0d", stepNum, checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* dv/cp0_stim.txt */
// wrEn wrAddr wrData excType excPc inDelaySlot excBadAddr hwIrq rdAddr check expected
// check: 0 none, 1 rdData, 2 {statusExl,causeIp}, 3 epc; excType 2 IfAddr 3 LoadAddr 6 Sys 9 Ov a Eret
0 00 00000000 0 00000000 0 00000000 00 0c 1 00400000
0 00 00000000 0 00000000 0 00000000 00 0b 1 ffffffff
0 00 00000000 0 00000000 0 00000000 00 0f 1 00004220
0 00 00000000 0 00000000 0 00000000 00 0d 2 00000000
0 00 00000000 0 00000000 0 00000000 00 03 1 00000000
1 0c ffffffff 0 00000000 0 00000000 00 0c 1 0040ff03
1 0c 0000ff01 0 00000000 0 00000000 00 0c 1 0000ff01
1 0d ffffffff 0 00000000 0 00000000 00 0d 1 00000300
1 0d 00000000 0 00000000 0 00000000 00 0d 1 00000000
1 0e 12345678 0 00000000 0 00000000 00 0e 1 12345678
1 0b cafe0000 0 00000000 0 00000000 00 0b 1 cafe0000
1 0f 00000000 0 00000000 0 00000000 00 0f 1 00004220
1 0b 00000103 0 00000000 0 00000000 00 0b 1 00000103
1 09 00000100 0 00000000 0 00000000 00 09 1 00000100
0 00 00000000 0 00000000 0 00000000 00 09 1 00000100
0 00 00000000 0 00000000 0 00000000 00 09 1 00000101
0 00 00000000 0 00000000 0 00000000 00 0d 1 00000000
0 00 00000000 0 00000000 0 00000000 00 09 1 00000102
0 00 00000000 0 00000000 0 00000000 00 0d 1 00000000
0 00 00000000 0 00000000 0 00000000 00 09 1 00000103
0 00 00000000 0 00000000 0 00000000 00 0d 1 40008000
0 00 00000000 0 00000000 0 00000000 00 0d 1 40008000
0 00 00000000 0 00000000 0 00000000 00 0d 1 40000000
1 0b ffffffff 0 00000000 0 00000000 00 0d 1 00000000
0 00 00000000 6 bfc00104 1 00000000 00 0c 1 0000ff03
0 00 00000000 0 00000000 0 00000000 00 0e 3 bfc00100
0 00 00000000 0 00000000 0 00000000 00 0d 1 80000020
0 00 00000000 9 80001000 0 00000000 00 0d 1 80000030
0 00 00000000 0 00000000 0 00000000 00 0e 1 bfc00100
0 00 00000000 3 80000200 0 00001233 00 08 1 00001233
0 00 00000000 2 80000402 0 00000000 00 08 1 80000402
0 00 00000000 a 00000000 0 00000000 00 0c 1 0000ff01
0 00 00000000 0 00000000 0 00000000 00 0e 1 bfc00100
0 00 00000000 0 00000000 0 00000000 2a 00 2 000000a8
0 00 00000000 0 00000000 0 00000000 15 0d 1 80005410

/* exception/cp0ExcDecode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Turns the pipeline's exception report into entry/ERET,
// ExcCode, the BadVAddr value and the EPC candidate.
// Purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

module cp0ExcDecode (
    input  cp0ExcPkg::excType_e      excType,
    input  logic [`CP0_DATA_W-1:0]   excPc,
    input  logic                     excInDelaySlot,
    input  logic [`CP0_DATA_W-1:0]   excBadAddr,
    cp0ExcIf.decoder                 excBus
);
    import cp0ExcPkg::*;

    always_comb begin
        excBus.trap = (excType != ExcNone) && (excType != ExcRefetch) && (excType != ExcEret);
        excBus.eret = (excType == ExcEret);

        excBus.codeValid = 1'b1;
        case (excType)
            ExcInterrupt:     excBus.code = CodeInt;
            ExcIfAddrErr:     excBus.code = CodeAdEL;
            ExcLoadAddrErr:   excBus.code = CodeAdEL;
            ExcStoreAddrErr:  excBus.code = CodeAdES;
            ExcReservedInstr: excBus.code = CodeRi;
            ExcSyscall:       excBus.code = CodeSys;
            ExcBreak:         excBus.code = CodeBp;
            ExcTrap:          excBus.code = CodeTr;
            ExcOverflow:      excBus.code = CodeOv;
            default: begin    // None, ERET, refetch
                excBus.codeValid = 1'b0;
                excBus.code      = CodeInt;
            end
        endcase

        // Faulting address for BadVAddr
        excBus.badAddrValid = 1'b1;
        case (excType)
            ExcIfAddrErr:    excBus.badAddr = excPc;
            ExcLoadAddrErr:  excBus.badAddr = excBadAddr;
            ExcStoreAddrErr: excBus.badAddr = excBadAddr;
            default: begin
                excBus.badAddrValid = 1'b0;
                excBus.badAddr      = excBadAddr;
            end
        endcase
    end

    // Restart at the branch when the victim sits in a delay slot
    assign excBus.epcCandidate = excInDelaySlot ? excPc - `CP0_DS_OFFSET : excPc;
    assign excBus.inDelaySlot  = excInDelaySlot;

endmodule

/* exception/cp0ExcUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exception state of CP0: Status, EPC, BadVAddr,
// Cause.BD and Cause.ExcCode.
// Takes the decoded report and software writes,
// exception entry wins over a write in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

module cp0ExcUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  cp0RegPkg::cp0WrReq_t     wrReq,
    cp0ExcIf.unit                    excBus,
    output cp0RegPkg::cp0Status_t    status,
    output logic [`CP0_DATA_W-1:0]   epc,
    output logic [`CP0_DATA_W-1:0]   badVAddr,
    output logic                     causeBd,
    output cp0ExcPkg::excCode_e      excCode
);
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    logic wrStatus;
    logic wrEpc;
    logic wrBadVAddr;
    logic excPresent;
    logic firstEntry;

    assign wrStatus   = wrReq.en && (wrReq.addr == RegStatus);
    assign wrEpc      = wrReq.en && (wrReq.addr == RegEpc);
    assign wrBadVAddr = wrReq.en && (wrReq.addr == RegBadVAddr);
    assign excPresent = excBus.trap || excBus.eret;
    assign firstEntry = excBus.trap && !status.exl;    // Nested entries keep EPC and BD

    always_ff @(posedge clk) begin
        if (!rstN) begin
            status <= '{bev: 1'b1, im: 8'h00, exl: 1'b0, ie: 1'b0};
        end else if (excBus.trap) begin
            status.exl <= 1'b1;
        end else if (excBus.eret) begin
            status.exl <= 1'b0;
        end else if (wrStatus) begin
            status <= '{bev: wrReq.data[22], im: wrReq.data[15:8],
                        exl: wrReq.data[1], ie: wrReq.data[0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            epc     <= '0;
            causeBd <= 1'b0;
        end else if (firstEntry) begin
            epc     <= excBus.epcCandidate;
            causeBd <= excBus.inDelaySlot;
        end else if (wrEpc && !excPresent) begin
            epc <= wrReq.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            excCode <= CodeInt;
        end else if (excBus.codeValid) begin
            excCode <= excBus.code;
        end
    end

    // Fault address first, software write otherwise
    always_ff @(posedge clk) begin
        if (!rstN) begin
            badVAddr <= '0;
        end else if (excBus.badAddrValid) begin
            badVAddr <= excBus.badAddr;
        end else if (wrBadVAddr) begin
            badVAddr <= wrReq.data;
        end
    end

endmodule

/* list.f */
+incdir+common
common/cp0RegPkg.sv
common/cp0ExcPkg.sv
common/cp0ExcIf.sv
exception/cp0ExcDecode.sv
exception/cp0ExcUnit.sv
timer/cp0Interrupts.sv
design/cp0ReadMux.sv
design/cp0Top.sv
dv/cp0ClkGen.sv
dv/cp0Tb.sv

/* timer/cp0Interrupts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Count/Compare timer and the Cause interrupt bits.
// Count steps every second clock, a match raises
// Cause.TI and IP7. Hardware lines land in IP7..2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cp0_defines.svh"

module cp0Interrupts (
    input  logic                       clk,
    input  logic                       rstN,
    input  cp0RegPkg::cp0WrReq_t       wrReq,
    input  logic [`CP0_HW_IRQ_N-1:0]   hwIrq,
    output logic [`CP0_DATA_W-1:0]     count,
    output logic [`CP0_DATA_W-1:0]     compare,
    output logic                       causeTi,
    output logic [7:0]                 causeIp
);
    import cp0RegPkg::*;

    logic                      countPhase;
    logic                      timerMatch;
    logic                      wrCount;
    logic                      wrCompare;
    logic                      wrCause;
    logic [`CP0_HW_IRQ_N-1:0]  irqMerged;
    logic [`CP0_HW_IRQ_N-1:0]  ipHw;       // IP7..2
    logic [1:0]                ipSw;       // IP1..0

    assign wrCount   = wrReq.en && (wrReq.addr == RegCount);
    assign wrCompare = wrReq.en && (wrReq.addr == RegCompare);
    assign wrCause   = wrReq.en && (wrReq.addr == RegCause);

    assign timerMatch = (count == compare);
    // Timer shares the top line
    assign irqMerged  = hwIrq | {timerMatch, {(`CP0_HW_IRQ_N-1){1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            countPhase <= 1'b0;
            count      <= '0;
        end else if (wrCount) begin
            countPhase <= 1'b0;    // Restart the two-clock prescale
            count      <= wrReq.data;
        end else begin
            countPhase <= !countPhase;
            if (countPhase)
                count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            compare <= `CP0_COMPARE_RST;
            causeTi <= 1'b0;
        end else if (wrCompare) begin
            compare <= wrReq.data;
            causeTi <= 1'b0;       // Writing Compare acknowledges the timer
        end else if (timerMatch) begin
            causeTi <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ipHw <= '0;
            ipSw <= '0;
        end else begin
            ipHw <= irqMerged;
            if (wrCause)
                ipSw <= wrReq.data[9:8];
        end
    end

    assign causeIp = {ipHw, ipSw};

endmodule
